/* hdl/uart_link_pkg.sv */
`default_nettype none

package uart_link_pkg;

  // host command with read flag, 7-bit address and write data
  typedef logic [15:0] cmd_t;

  // one frame payload
  typedef logic [7:0] byte_t;

  // remote register address
  typedef logic [6:0] addr_t;

  // command sequencer
  typedef enum logic [1:0] {
    st_idle,
    st_send_hi,
    st_send_lo,
    st_wait_reply
  } link_state_t;

  // start, 8 data, parity, stop
  localparam int frame_bits = 11;

  // baud counter width
  localparam int cnt_w = 16;

endpackage

`default_nettype wire

/* hdl/frame_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_tx
  import uart_link_pkg::*;
#(
  parameter int clks_per_bit = 8
) (
  input  wire         clk,
  input  wire         rst_n,
  input  wire byte_t  tx_byte,
  input  wire         tx_start,
  output logic        tx_busy,
  output logic        tx_done,
  output logic        tx
);

  localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);
  localparam logic [3:0]       bit_last  = 4'(frame_bits - 1);

  logic [cnt_w-1:0]      baud_cnt;
  logic [3:0]            bit_cnt;
  // bits still to go after the start bit
  logic [frame_bits-2:0] shreg;
  logic                  load;
  logic                  bit_end;

  assign load    = tx_start && !tx_busy;
  assign bit_end = tx_busy && (baud_cnt == baud_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy  <= 1'b0;
      tx_done  <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      tx_done <= 1'b0;
      if (load) begin
        tx_busy  <= 1'b1;
        tx       <= 1'b0;
        baud_cnt <= '0;
        bit_cnt  <= '0;
      end else if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == bit_last) begin
          // stop bit done and line stays high
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
          tx      <= shreg[0];
        end
      end else if (tx_busy) begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // odd parity over the data byte
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    end else if (bit_end) begin
      shreg <= {1'b1, shreg[frame_bits-2:1]};
    end
  end

endmodule

`default_nettype wire

/* hdl/frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_rx
  import uart_link_pkg::*;
#(
  parameter int clks_per_bit = 8,
  parameter bit parity_check = 1'b1
) (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   rx,
  output byte_t rx_byte,
  output logic  rx_ok,
  output logic  rx_bad
);

  localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);
  localparam logic [cnt_w-1:0] baud_mid  = cnt_w'(clks_per_bit / 2);
  localparam logic [3:0]       bit_last  = 4'(frame_bits - 1);
  localparam logic [3:0]       bit_par   = 4'(frame_bits - 2);

  logic             rx_s1;
  logic             rx_s2;
  logic             rx_d;
  logic             fall;
  logic             busy;
  logic [cnt_w-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic             mid;
  byte_t            shreg;
  logic             par_bit;
  logic             frame_bad;

  // two-flop synchronizer and edge-detect flop reset high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  assign fall = rx_d && !rx_s2;
  assign mid  = busy && (baud_cnt == baud_mid);

  // evaluated at the stop bit where rx_s2 holds the stop level
  assign frame_bad = !rx_s2 || (parity_check && !(^{shreg, par_bit}));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_ok    <= 1'b0;
      rx_bad   <= 1'b0;
    end else begin
      rx_ok  <= 1'b0;
      rx_bad <= 1'b0;
      if (!busy) begin
        if (fall) begin
          busy     <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else begin
        if (baud_cnt == baud_last) begin
          baud_cnt <= '0;
          bit_cnt  <= bit_cnt + 4'd1;
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        if (mid) begin
          if (bit_cnt == 4'd0 && rx_s2) begin
            // line back high so only a glitch
            busy <= 1'b0;
          end else if (bit_cnt == bit_last) begin
            busy   <= 1'b0;
            rx_ok  <= !frame_bad;
            rx_bad <= frame_bad;
          end
        end
      end
    end
  end

  // data LSB first followed by parity
  always_ff @(posedge clk) begin
    if (mid) begin
      if (bit_cnt != 4'd0 && bit_cnt < bit_par) begin
        shreg <= {rx_s2, shreg[7:1]};
      end else if (bit_cnt == bit_par) begin
        par_bit <= rx_s2;
      end else if (bit_cnt == bit_last) begin
        rx_byte <= shreg;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_decode
  import uart_link_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  wire cmd_t   cmd_in,
  input  wire         cmd_vld,
  output logic        cmd_rdy,
  output byte_t       tx_byte,
  output logic        tx_start,
  input  wire         tx_busy,
  input  wire         tx_done,
  input  wire         rx_ok,
  input  wire         rx_bad,
  output logic        read_rdy,
  output logic        rx_err
);

  link_state_t state;
  cmd_t        cmd_q;
  logic        hi_pend;
  logic        accept;

  assign accept  = cmd_vld && cmd_rdy;
  assign cmd_rdy = (state == st_idle);

  // high byte first and low byte in st_send_lo
  assign tx_byte = (state == st_send_lo) ? cmd_q[7:0] : cmd_q[15:8];

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      hi_pend  <= 1'b0;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      rx_err   <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      rx_err   <= 1'b0;

      case (state)
        st_idle: begin
          if (accept) begin
            state   <= st_send_hi;
            hi_pend <= 1'b1;
          end
        end

        st_send_hi: begin
          if (hi_pend && !tx_busy) begin
            tx_start <= 1'b1;
            hi_pend  <= 1'b0;
          end else if (tx_done) begin
            // back-to-back frame with a two-cycle gap on the line
            tx_start <= 1'b1;
            state    <= st_send_lo;
          end
        end

        st_send_lo: begin
          if (tx_done) begin
            // bit 15 set means a reply is owed
            state <= cmd_q[15] ? st_wait_reply : st_idle;
          end
        end

        st_wait_reply: begin
          if (rx_ok) begin
            read_rdy <= 1'b1;
            state    <= st_idle;
          end else if (rx_bad) begin
            rx_err <= 1'b1;
            state  <= st_idle;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/uart_link.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_link
  import uart_link_pkg::*;
#(
  parameter int clks_per_bit = 8,
  parameter bit parity_check = 1'b1
) (
  input  wire        clk,
  input  wire        rst_n,
  input  wire cmd_t  cmd_in,
  input  wire        cmd_vld,
  output logic       cmd_rdy,
  input  wire        rx,
  output logic       tx,
  output logic       read_rdy,
  output byte_t      read_data,
  output logic       rx_err
);

  byte_t tx_byte;
  logic  tx_start;
  logic  tx_busy;
  logic  tx_done;
  logic  rx_ok;
  logic  rx_bad;

  cmd_decode u_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done),
    .rx_ok    (rx_ok),
    .rx_bad   (rx_bad),
    .read_rdy (read_rdy),
    .rx_err   (rx_err)
  );

  frame_tx #(
    .clks_per_bit (clks_per_bit)
  ) u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // reply byte goes straight out as read_data
  frame_rx #(
    .clks_per_bit (clks_per_bit),
    .parity_check (parity_check)
  ) u_result (
    .clk     (clk),
    .rst_n   (rst_n),
    .rx      (rx),
    .rx_byte (read_data),
    .rx_ok   (rx_ok),
    .rx_bad  (rx_bad)
  );

endmodule

`default_nettype wire

/* dv/uart_link_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_link_asserts (
  input wire clk,
  input wire rst_n,
  input wire cmd_rdy,
  input wire tx,
  input wire read_rdy,
  input wire rx_err,
  input wire tx_start,
  input wire tx_busy
);

  // a reply is good or bad but never both
  reply_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(read_rdy && rx_err))
    else $error("read_rdy and rx_err high in the same cycle");

  read_rdy_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy longer than one cycle");

  rx_err_single: assert property (@(posedge clk) disable iff (!rst_n)
    rx_err |=> !rx_err)
    else $error("rx_err longer than one cycle");

  // line idles high whenever the link is free
  idle_line: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  start_when_free: assert property (@(posedge clk) disable iff (!rst_n)
    tx_start |-> !tx_busy)
    else $error("tx_start while the transmitter is busy");

endmodule

`default_nettype wire

/* dv/tb_uart_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link
  import uart_link_pkg::*;
();

  localparam int clks_per_bit = 8;
  localparam int n_commands   = 200;

  logic  clk = 1'b0;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  cmd_rdy;
  logic  rx;
  logic  tx;
  logic  read_rdy;
  byte_t read_data;
  logic  rx_err;

  logic [31:0] lfsr_state = 32'h139c_6f5e;
  // remote register file
  byte_t       regs [128];
  int          ok_cnt = 0;
  int          err_cnt = 0;

  uart_link #(
    .clks_per_bit (clks_per_bit),
    .parity_check (1'b1)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .rx_err    (rx_err)
  );

  bind uart_link uart_link_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_rdy (read_rdy),
    .rx_err   (rx_err),
    .tx_start (tx_start),
    .tx_busy  (tx_busy)
  );

  always #20 clk = ~clk;

  // reply pulses seen on the host side
  always @(posedge clk) begin
    if (read_rdy === 1'b1) begin
      ok_cnt <= ok_cnt + 1;
    end
    if (rx_err === 1'b1) begin
      err_cnt <= err_cnt + 1;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TEST RESULT: FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "wait did not finish");
  endtask

  task automatic issue_command(input cmd_t cmd);
    int waited;
    waited = 0;
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 16) begin
        abort_on_timeout("command was never accepted");
      end
    end while (cmd_rdy !== 1'b1);
    cmd_vld <= 1'b0;
  endtask

  task automatic wait_cmd_rdy();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 4 * clks_per_bit) begin
        abort_on_timeout("cmd_rdy did not return high");
      end
    end while (cmd_rdy !== 1'b1);
  endtask

  // remote side of tx sampled near mid-bit
  task automatic receive_frame(input int exp_wait, input logic inject, output byte_t data);
    int    waited;
    byte_t d;
    logic  par;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 2 * clks_per_bit + 8) begin
        abort_on_timeout("no start bit on tx");
      end
    end while (tx !== 1'b0);
    compare("tx start delay", waited, exp_wait);
    repeat (clks_per_bit / 2) @(posedge clk);
    compare("tx start bit", tx, 0);
    for (int i = 0; i < 8; i++) begin
      repeat (clks_per_bit) @(posedge clk);
      d[i] = tx;
      // a command while busy must be ignored
      if (inject && i == 3) begin
        cmd_in  <= cmd_t'(random_bits(16));
        cmd_vld <= 1'b1;
      end else begin
        cmd_vld <= 1'b0;
      end
    end
    repeat (clks_per_bit) @(posedge clk);
    par = tx;
    compare("tx parity", ^{d, par}, 1);
    repeat (clks_per_bit) @(posedge clk);
    compare("tx stop bit", tx, 1);
    data = d;
  endtask

  task automatic send_frame(input byte_t data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      rx <= bits[i];
      repeat (clks_per_bit) @(posedge clk);
    end
  endtask

  // low pulse shorter than half a bit
  task automatic glitch_rx();
    int len;
    len = 1 + int'(random_bits(2) % (clks_per_bit / 2 - 1));
    rx <= 1'b0;
    repeat (len) @(posedge clk);
    rx <= 1'b1;
    repeat (clks_per_bit) @(posedge clk);
  endtask

  initial begin : main
    cmd_t  cmd;
    byte_t hi;
    byte_t lo;
    addr_t addr;
    logic  bad;
    logic  inject;
    int    idle;
    int    exp_ok;
    int    exp_err;

    exp_ok  = 0;
    exp_err = 0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    for (int i = 0; i < 128; i++) begin
      regs[i] = byte_t'(i * 37 + 11);
    end

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    compare("cmd_rdy", cmd_rdy, 1);
    compare("tx", tx, 1);
    compare("read_rdy", read_rdy, 0);
    compare("rx_err", rx_err, 0);

    for (int n = 0; n < n_commands; n++) begin
      cmd    = cmd_t'(random_bits(16));
      inject = random_bits(1);
      bad    = 1'b0;
      issue_command(cmd);
      // start bit seen one edge after its 2-cycle delay
      receive_frame(3, inject, hi);
      compare("tx high byte", hi, cmd[15:8]);
      // rest of the stop bit plus the 2-cycle gap
      receive_frame(clks_per_bit - clks_per_bit / 2 + 2, inject, lo);
      compare("tx low byte", lo, cmd[7:0]);
      addr = hi[6:0];

      if (!hi[7]) begin
        regs[addr] = lo;
      end else begin
        bad = (random_bits(3) == 0);
        // reply owed once the stop bit is past
        repeat (clks_per_bit) @(posedge clk);
        if (random_bits(2) == 0) begin
          glitch_rx();
        end
        repeat ((1 + random_bits(2)) * clks_per_bit) @(posedge clk);
        send_frame(regs[addr], bad);
        if (bad) begin
          exp_err++;
        end else begin
          exp_ok++;
        end
      end

      wait_cmd_rdy();
      if (hi[7] && !bad) begin
        compare("read_data", read_data, regs[addr]);
      end

      idle = int'(random_bits(3));
      for (int i = 0; i <= idle; i++) begin
        @(posedge clk);
        compare("tx idle", tx, 1);
      end
      if (random_bits(2) == 0) begin
        glitch_rx();
      end
      compare("read_rdy count", ok_cnt, exp_ok);
      compare("rx_err count", err_cnt, exp_err);
    end

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hdl/uart_link_pkg.sv
hdl/frame_tx.sv
hdl/frame_rx.sv
hdl/cmd_decode.sv
hdl/uart_link.sv
dv/uart_link_asserts.sv
dv/tb_uart_link.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_uart_link
SEED_ARGS ?=
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a listed source or the list itself changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(SEED_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
